// File: source/alu_pkg.sv
// ALU operation enum, funct3 field type and RV32I funct3 codes for OP/OP-IMM
package alu_pkg;

    // funct3 field of an OP or OP-IMM instruction
    typedef logic [2:0] funct3_t;

    // operation selected for the execute stage
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // funct3 encodings shared by register and immediate forms
    localparam funct3_t F3_ADD_SUB = 3'b000;  // ADD/SUB, ADDI
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;  // bit 30 picks SRA
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

endpackage

// File: source/shift_if.sv
// shift_if interface with shifter controls, data, result and its two modports
`timescale 1ns/1ps

interface shift_if #(
    parameter int XLEN = 32
);
    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]    in_data;
    logic [SHAMT_W-1:0] shamt;
    logic               left_or_right_shift;     // 1 = right, as funct3[2]
    logic               arithmetic_right_shift;  // sign fill on right shift
    logic [XLEN-1:0]    out_data;

    // side that requests a shift
    modport requester (
        output in_data,
        output shamt,
        output left_or_right_shift,
        output arithmetic_right_shift,
        input  out_data
    );

    modport shifter (
        input  in_data,
        input  shamt,
        input  left_or_right_shift,
        input  arithmetic_right_shift,
        output out_data
    );

endinterface

// File: source/alu_op_decoder.sv
// alu_op_decoder module mapping funct3, instruction bit 30 and OP-IMM flag to an ALU op
`timescale 1ns/1ps

module alu_op_decoder (
    input  alu_pkg::funct3_t funct3,
    input  logic             instr_bit30,
    input  logic             is_imm,
    output alu_pkg::alu_op_e alu_op
);

    always_comb begin
        case (funct3)
            alu_pkg::F3_ADD_SUB: begin
                // ADDI has no sub form, bit 30 is immediate data there
                if (instr_bit30 && !is_imm) begin
                    alu_op = alu_pkg::ALU_SUB;
                end else begin
                    alu_op = alu_pkg::ALU_ADD;
                end
            end
            alu_pkg::F3_SLL:     alu_op = alu_pkg::ALU_SLL;
            alu_pkg::F3_SLT:     alu_op = alu_pkg::ALU_SLT;
            alu_pkg::F3_SLTU:    alu_op = alu_pkg::ALU_SLTU;
            alu_pkg::F3_XOR:     alu_op = alu_pkg::ALU_XOR;
            alu_pkg::F3_SRL_SRA: begin
                // same rule for SRAI and SRA
                if (instr_bit30) begin
                    alu_op = alu_pkg::ALU_SRA;
                end else begin
                    alu_op = alu_pkg::ALU_SRL;
                end
            end
            alu_pkg::F3_OR:      alu_op = alu_pkg::ALU_OR;
            alu_pkg::F3_AND:     alu_op = alu_pkg::ALU_AND;
            default:             alu_op = alu_pkg::ALU_ADD;
        endcase
    end

endmodule

// File: source/full_barrel_shifter.sv
// full_barrel_shifter module, log-depth SLL/SRL/SRA shifter on the shifter modport
`timescale 1ns/1ps

module full_barrel_shifter #(
    parameter int XLEN = 32
) (
    shift_if.shifter shift
);

    localparam int STAGES = $clog2(XLEN);

    typedef logic [XLEN-1:0] word_t;

    word_t stage_data [STAGES+1];  // stage_data[i] feeds stage i
    word_t shifted    [STAGES];    // stage i input moved by 2**i
    logic  fill_bit;               // vacated bits on a right shift

    assign stage_data[0]  = shift.in_data;
    assign shift.out_data = stage_data[STAGES];

    // sign of the original operand, only for SRA
    assign fill_bit = shift.arithmetic_right_shift & shift.in_data[XLEN-1];

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        localparam int DIST = 1 << i;

        for (genvar j = 0; j < XLEN; j++) begin : g_bit
            logic from_left;   // bit j after a left move
            logic from_right;  // bit j after a right move

            if (j < DIST) begin : g_left_src
                assign from_left = 1'b0;  // zeros shifted in at lsb
            end else begin : g_left_src
                assign from_left = stage_data[i][j-DIST];
            end

            if (j + DIST >= XLEN) begin : g_right_src
                assign from_right = fill_bit;
            end else begin : g_right_src
                assign from_right = stage_data[i][j+DIST];
            end

            // direction pre-select
            assign shifted[i][j] = shift.left_or_right_shift ? from_right : from_left;
        end

        // pass through or take the moved word, per shamt bit
        assign stage_data[i+1] = shift.shamt[i] ? shifted[i] : stage_data[i];
    end

endmodule

// File: source/add_compare_unit.sv
// add_compare_unit module, shared add/subtract with signed and unsigned less-than
`timescale 1ns/1ps

module add_compare_unit #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  logic            subtract,
    output logic [XLEN-1:0] sum,
    output logic            less_signed,
    output logic            less_unsigned
);

    logic [XLEN-1:0] b_eff;     // b or ~b
    logic [XLEN:0]   full_sum;  // carry out in the top bit
    logic            sign_diff;

    // a - b as a + ~b + 1
    assign b_eff    = subtract ? ~operand_b : operand_b;
    assign full_sum = {1'b0, operand_a} + {1'b0, b_eff} + {{XLEN{1'b0}}, subtract};
    assign sum      = full_sum[XLEN-1:0];

    // no carry out of a + ~b + 1 means a borrow, so a < b unsigned
    assign less_unsigned = ~full_sum[XLEN];

    assign sign_diff = operand_a[XLEN-1] ^ operand_b[XLEN-1];

    // differing signs: the negative one is smaller
    // same signs: difference cannot overflow, its sign decides
    assign less_signed = sign_diff ? operand_a[XLEN-1] : full_sum[XLEN-1];

endmodule

// File: source/alu_core.sv
// alu_core module, combinational RV32I ALU with adder, barrel shifter and logic ops
`timescale 1ns/1ps

module alu_core #(
    parameter int XLEN = 32
) (
    input  alu_pkg::alu_op_e alu_op,
    input  logic [XLEN-1:0]  operand_a,
    input  logic [XLEN-1:0]  operand_b,
    output logic [XLEN-1:0]  alu_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic            subtract;
    logic [XLEN-1:0] sum;
    logic            less_signed;
    logic            less_unsigned;
    logic [XLEN-1:0] xor_result;
    logic [XLEN-1:0] or_result;
    logic [XLEN-1:0] and_result;

    // SLT/SLTU reuse the subtractor
    assign subtract = (alu_op == alu_pkg::ALU_SUB) ||
                      (alu_op == alu_pkg::ALU_SLT) ||
                      (alu_op == alu_pkg::ALU_SLTU);

    add_compare_unit #(
        .XLEN (XLEN)
    ) add_compare_unit_inst (
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .subtract      (subtract),
        .sum           (sum),
        .less_signed   (less_signed),
        .less_unsigned (less_unsigned)
    );

    // requester side of the shifter link
    shift_if #(.XLEN(XLEN)) shift_bus ();

    assign shift_bus.in_data = operand_a;
    assign shift_bus.shamt   = operand_b[SHAMT_W-1:0];  // upper bits ignored
    assign shift_bus.left_or_right_shift =
        (alu_op == alu_pkg::ALU_SRL) || (alu_op == alu_pkg::ALU_SRA);
    assign shift_bus.arithmetic_right_shift = (alu_op == alu_pkg::ALU_SRA);

    full_barrel_shifter #(
        .XLEN (XLEN)
    ) full_barrel_shifter_inst (
        .shift (shift_bus.shifter)
    );

    assign xor_result = operand_a ^ operand_b;
    assign or_result  = operand_a | operand_b;
    assign and_result = operand_a & operand_b;

    always_comb begin
        case (alu_op)
            alu_pkg::ALU_ADD,
            alu_pkg::ALU_SUB:  alu_result = sum;
            alu_pkg::ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, less_signed};
            alu_pkg::ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, less_unsigned};
            alu_pkg::ALU_SLL,
            alu_pkg::ALU_SRL,
            alu_pkg::ALU_SRA:  alu_result = shift_bus.out_data;
            alu_pkg::ALU_XOR:  alu_result = xor_result;
            alu_pkg::ALU_OR:   alu_result = or_result;
            alu_pkg::ALU_AND:  alu_result = and_result;
            default:           alu_result = sum;  // unused enum codes
        endcase
    end

endmodule

// File: source/alu_stage.sv
// alu_stage module, registered execute-stage ALU with valid strobe
`timescale 1ns/1ps

module alu_stage #(
    parameter int XLEN = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  logic [XLEN-1:0]  operand_a,
    input  logic [XLEN-1:0]  operand_b,
    input  alu_pkg::funct3_t funct3,
    input  logic             instr_bit30,
    input  logic             is_imm,
    output logic [XLEN-1:0]  result,
    output logic             valid_out
);

    alu_pkg::alu_op_e alu_op;
    logic [XLEN-1:0]  alu_result;  // combinational, captured below

    alu_op_decoder alu_op_decoder_inst (
        .funct3      (funct3),
        .instr_bit30 (instr_bit30),
        .is_imm      (is_imm),
        .alu_op      (alu_op)
    );

    alu_core #(
        .XLEN (XLEN)
    ) alu_core_inst (
        .alu_op     (alu_op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_result (alu_result)
    );

    // one cycle latency, a new op can enter every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // result holds while no new op arrives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (valid_in) begin
            result <= alu_result;
        end
    end

endmodule

// File: dv/tb_clock_gen.sv
// tb_clock_gen module, free-running testbench clock
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half low
    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// File: dv/alu_stage_tb.sv
// alu_stage_tb module, file-driven testbench for the registered ALU stage
`timescale 1ns/1ps

module alu_stage_tb;

    localparam int XLEN           = 32;
    localparam int NUM_VEC        = 38;
    localparam int VEC_W          = 108;  // 8 + 8 + 3 + 8 hex digits
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_VEC + RESET_CYCLES + 20;

    logic             clk;
    logic             rst_n;
    logic             valid_in;
    logic [XLEN-1:0]  operand_a;
    logic [XLEN-1:0]  operand_b;
    alu_pkg::funct3_t funct3;
    logic             instr_bit30;
    logic             is_imm;
    logic [XLEN-1:0]  result;
    logic             valid_out;

    logic [VEC_W-1:0] stim_mem [NUM_VEC];
    int               pass_count;
    int               fail_count;
    int               cycle_count;

    tb_clock_gen #(
        .PERIOD_NS (8.0)
    ) tb_clock_gen_inst (
        .clk (clk)
    );

    alu_stage #(
        .XLEN (XLEN)
    ) alu_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .funct3      (funct3),
        .instr_bit30 (instr_bit30),
        .is_imm      (is_imm),
        .result      (result),
        .valid_out   (valid_out)
    );

    function automatic logic [XLEN-1:0] expected_of(input int idx);
        return stim_mem[idx][31:0];
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // field layout follows the stim file columns
    task automatic drive_vector(input int idx);
        valid_in    = 1'b1;
        operand_a   = stim_mem[idx][107:76];
        operand_b   = stim_mem[idx][75:44];
        funct3      = stim_mem[idx][42:40];
        instr_bit30 = stim_mem[idx][36];
        is_imm      = stim_mem[idx][32];
    endtask

    task automatic drive_idle();
        valid_in  = 1'b0;
        operand_a = 32'hdead_beef;  // junk that must not reach result
        operand_b = 32'h0bad_f00d;
    endtask

    task automatic check_vector(input int idx);
        string tag;
        tag = $sformatf("vector %0d", idx);
        check_value({tag, " valid_out"}, {31'b0, valid_out}, 32'd1);
        check_value({tag, " result"}, result, expected_of(idx));
    endtask

    // streams lines first..last back to back, one idle cycle after gap_after
    task automatic run_group(input string name, input int first, input int last,
                             input int gap_after);
        int pass_before;
        int fail_before;
        int pending;
        pass_before = pass_count;
        fail_before = fail_count;
        pending     = -1;
        @(negedge clk);
        for (int i = first; i <= last; i++) begin
            if (pending >= 0) begin
                check_vector(pending);
            end
            drive_vector(i);
            pending = i;
            @(negedge clk);
            if (i == gap_after) begin
                check_vector(i);
                pending = -1;
                drive_idle();
                @(negedge clk);
                check_value("valid_out in gap", {31'b0, valid_out}, 32'd0);
                check_value("result held in gap", result, expected_of(i));
            end
        end
        if (pending >= 0) begin
            check_vector(pending);
        end
        drive_idle();
        $display("test %s: %0d checks, %0d failed", name,
                 (pass_count - pass_before) + (fail_count - fail_before),
                 fail_count - fail_before);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        operand_a   = '0;
        operand_b   = '0;
        funct3      = alu_pkg::F3_ADD_SUB;
        instr_bit30 = 1'b0;
        is_imm      = 1'b0;

        $readmemh("dv/alu_stim.txt", stim_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // outputs straight out of reset
        check_value("valid_out after reset", {31'b0, valid_out}, 32'd0);
        check_value("result after reset", result, 32'd0);
        $display("test reset: 2 checks, %0d failed", fail_count);

        run_group("add_sub", 0, 5, -1);
        run_group("compare", 6, 13, -1);
        run_group("shift", 14, 25, -1);
        run_group("logic", 26, 32, -1);
        run_group("stream_gap", 33, 37, 35);  // gap after line 35

        $display("total: %0d checks passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: dv/alu_stim.txt
// columns: operand_a _ operand_b _ funct3 _ instr_bit30 _ is_imm _ expected result
// all hex, one digit for each control field
// add_sub, lines 0 to 5
00000005_00000003_0_0_0_00000008
00000005_00000003_0_1_0_00000002
00000005_00000003_0_1_1_00000008
ffffffff_00000002_0_0_0_00000001
00000000_00000001_0_1_0_ffffffff
7fffffff_00000001_0_0_0_80000000
// compare, lines 6 to 13
ffffffff_00000001_2_0_0_00000001
ffffffff_00000001_3_0_0_00000000
00000001_ffffffff_2_0_0_00000000
00000001_ffffffff_3_0_0_00000001
80000000_7fffffff_2_0_0_00000001
80000000_7fffffff_3_0_0_00000000
fffffff0_fffffff8_2_0_1_00000001
12345678_12345678_2_0_0_00000000
// shift, lines 14 to 25
80000001_00000000_1_0_0_80000001
80000001_00000001_1_0_0_00000002
00000001_0000001f_1_0_0_80000000
00000001_00000021_1_0_0_00000002
80000000_00000001_5_0_0_40000000
80000000_0000001f_5_0_0_00000001
80000000_00000001_5_1_0_c0000000
80000000_0000001f_5_1_0_ffffffff
f0000000_ffffffe4_5_1_0_ff000000
7ffffff0_00000404_5_1_1_07ffffff
f0000000_00000000_5_0_0_f0000000
ffffffff_00000024_5_0_1_0fffffff
// logic, lines 26 to 32
aaaaaaaa_55555555_4_0_0_ffffffff
aaaaaaaa_ffff0000_4_0_0_5555aaaa
aaaaaaaa_55555555_6_0_0_ffffffff
a0a0a0a0_05050505_6_0_0_a5a5a5a5
aaaaaaaa_55555555_7_0_0_00000000
aaaaaaaa_f0f0f0f0_7_0_0_a0a0a0a0
aaaaaaaa_0000ffff_7_0_1_0000aaaa
// stream with a gap, lines 33 to 37
00000010_00000020_0_0_0_00000030
00000100_00000001_0_1_0_000000ff
00000003_00000004_1_0_0_00000030
0000ffff_00ff00ff_4_0_0_00ffff00
80000010_00000004_5_1_0_f8000001

// File: files.f
source/alu_pkg.sv
source/shift_if.sv
source/alu_op_decoder.sv
source/full_barrel_shifter.sv
source/add_compare_unit.sv
source/alu_core.sv
source/alu_stage.sv
dv/tb_clock_gen.sv
dv/alu_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ALU stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module alu_stage_tb \
    -f files.f \
    -o sim_alu_stage

output=$(./obj_dir/sim_alu_stage)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
